//--- all.f
clock_set_pkg.sv
key_hold.sv
cursor_ctrl.sv
date_regs.sv
date_display.sv
clock_set_top.sv
clock_set_tb.sv

//--- Bender.yml
package:
  name: clock_set

sources:
  - clock_set_pkg.sv
  - key_hold.sv
  - cursor_ctrl.sv
  - date_regs.sv
  - date_display.sv
  - clock_set_top.sv
  - target: simulation
    files:
      - clock_set_tb.sv

//--- clock_set_tb.sv
module clock_set_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int hold_cycles = 8;
    localparam int planned_presses = 1300;  // generous bound over all tests
    localparam int timeout_ns = 2 * planned_presses * (hold_cycles + 6) * 10;
    localparam int k_left = 0;
    localparam int k_right = 1;
    localparam int k_up = 2;
    localparam int k_down = 3;

    logic                                      clk;
    logic                                      reset;
    logic [3:0]                                mode;
    logic                                      key_left;
    logic                                      key_right;
    logic                                      key_up;
    logic                                      key_down;
    clock_set_pkg::date_time_t                 now;
    clock_set_pkg::weekday_t                   week;
    logic [clock_set_pkg::display_width - 1:0] set_string;
    clock_set_pkg::cursor_t                    cursor;

    clock_set_pkg::date_time_t model_date;
    clock_set_pkg::cursor_t    model_cur;
    logic [31:0]               lcg_state = 32'h6013bba6;
    int                        n_mismatch = 0;
    int                        n_other = 0;

    clock_set_top #(.hold_cycles(hold_cycles)) i_dut (.*);

    always #5 clk = ~clk;

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'((lcg_state >> 8) % n);  // low lcg bits are weak
    endfunction

    function automatic bit is_leap(input int y);
        return (y % 400 == 0) || (y % 4 == 0 && y % 100 != 0);
    endfunction

    function automatic int days_in_month(input int y, input int m);
        return (m == 2) ? (is_leap(y) ? 29 : 28) : ((m inside {4, 6, 9, 11}) ? 30 : 31);
    endfunction

    function automatic int bcd2_to_int(input logic [7:0] b);
        return int'(b[7:4]) * 10 + int'(b[3:0]);
    endfunction

    function automatic clock_set_pkg::date_time_t make_date(input int y, mo, d, h, mi, s);
        clock_set_pkg::date_time_t r;
        r.year = {4'(y / 1000), 4'(y / 100 % 10), 4'(y / 10 % 10), 4'(y % 10)};
        r.month = {4'(mo / 10), 4'(mo % 10)};
        r.day = {4'(d / 10), 4'(d % 10)};
        r.hour = {4'(h / 10), 4'(h % 10)};
        r.minute = {4'(mi / 10), 4'(mi % 10)};
        r.second = {4'(s / 10), 4'(s % 10)};
        return r;
    endfunction

    function automatic clock_set_pkg::bcd_digit_t digit_of(
        input clock_set_pkg::date_time_t d,
        input clock_set_pkg::cursor_t c
    );
        logic [55:0] flat;
        flat = d;
        return flat[(13 - int'(c)) * 4 +: 4];  // cursor 0 is the msb digit
    endfunction

    function automatic clock_set_pkg::weekday_t weekday_of(input clock_set_pkg::date_time_t d);
        int y;
        int m;
        int s;
        y = bcd2_to_int(d.year[3:2]) * 100 + bcd2_to_int(d.year[1:0]);
        m = bcd2_to_int(d.month);
        if (m < 3) begin
            m = m + 12;  // jan, feb belong to the year before
            y = y - 1;
        end
        s = bcd2_to_int(d.day) + 2 * m + 3 * (m + 1) / 5 + y + y / 4 - y / 100 + y / 400 + 1;
        return (s % 7 == 0) ? 4'd7 : 4'(s % 7);
    endfunction

    function automatic logic [83:0] pack_string(input clock_set_pkg::date_time_t d);
        return {d.year, 4'hb, d.month, 4'hb, d.day, 4'hb, weekday_of(d), 4'hb,
                d.hour, 4'hb, d.minute, 4'hb, d.second};
    endfunction

    // one up or down step of the digit under cursor c
    function automatic clock_set_pkg::date_time_t model_step(
        input clock_set_pkg::date_time_t d,
        input clock_set_pkg::cursor_t c,
        input bit up
    );
        logic [55:0] flat;
        int idx;
        int v;
        int lo;
        int hi;
        int yr;
        int mon;
        flat = d;
        idx = 13 - int'(c);
        v = flat[idx * 4 +: 4];
        yr = bcd2_to_int(d.year[3:2]) * 100 + bcd2_to_int(d.year[1:0]);
        mon = bcd2_to_int(d.month);
        lo = 0;
        hi = 9;
        case (c)
            clock_set_pkg::cur_year_u: lo = (yr < 10) ? 1 : 0;
            clock_set_pkg::cur_month_t: hi = 1;
            clock_set_pkg::cur_month_u: begin
                hi = (d.month[1] == 4'd1) ? 2 : 9;
                lo = (d.month[1] == 4'd1) ? 0 : 1;
            end
            clock_set_pkg::cur_day_t: hi = (mon == 2) ? 2 : 3;
            clock_set_pkg::cur_day_u: begin
                if (mon == 2 && d.day[1] == 4'd2) begin
                    hi = is_leap(yr) ? 9 : 8;
                end else if (mon != 2 && d.day[1] == 4'd3) begin
                    hi = (mon inside {1, 3, 5, 7, 8, 10, 12}) ? 1 : 0;
                end else if (d.day[1] == 4'd0) begin
                    lo = 1;
                end
            end
            clock_set_pkg::cur_hour_t: hi = 2;
            clock_set_pkg::cur_min_t, clock_set_pkg::cur_sec_t: hi = 5;
            default: ;
        endcase
        if (up) begin
            v = (v >= hi) ? lo : v + 1;
        end else begin
            v = (v <= lo) ? hi : v - 1;
        end
        flat[idx * 4 +: 4] = 4'(v);
        return flat;
    endfunction

    task automatic check_date(input clock_set_pkg::date_time_t got, exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("[FAIL] now: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_week(input clock_set_pkg::weekday_t got, exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("[FAIL] week: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_cursor(input clock_set_pkg::cursor_t got, exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("[FAIL] cursor: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_string(input logic [83:0] got, exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("[FAIL] set_string: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_all();
        check_date(now, model_date);
        check_cursor(cursor, model_cur);
        check_week(week, weekday_of(model_date));
        check_string(set_string, pack_string(model_date));
    endtask

    task automatic drive_key(input int k, input logic v);
        case (k)
            k_left: key_left <= v;
            k_right: key_right <= v;
            k_up: key_up <= v;
            default: key_down <= v;
        endcase
    endtask

    // hold for n cycles, release, wait 2 cycles, then track the expected effect
    task automatic hold_key(input int k, input int n);
        @(posedge clk);
        drive_key(k, 1'b1);
        repeat (n) @(posedge clk);
        drive_key(k, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (mode == clock_set_pkg::mode_set && n >= hold_cycles) begin
            case (k)
                k_left: model_cur = clock_set_pkg::cursor_t'((int'(model_cur) + 13) % 14);
                k_right: model_cur = clock_set_pkg::cursor_t'((int'(model_cur) + 1) % 14);
                k_up: model_date = model_step(model_date, model_cur, 1'b1);
                default: model_date = model_step(model_date, model_cur, 1'b0);
            endcase
        end
    endtask

    task automatic press_key(input int k);
        hold_key(k, hold_cycles + 4);
    endtask

    task automatic move_to(input clock_set_pkg::cursor_t target);
        repeat ((int'(target) - int'(model_cur) + 14) % 14) press_key(k_right);
    endtask

    task automatic set_digit(input clock_set_pkg::cursor_t c, input int v);
        int guard;
        guard = 0;
        move_to(c);
        while (int'(digit_of(model_date, c)) != v && guard < 16) begin
            press_key(k_up);
            guard++;
        end
        if (int'(digit_of(model_date, c)) != v) begin
            n_other++;
            $display("digit at cursor %0d never reached value %0d", c, v);
        end
    endtask

    task automatic step_and_check(input int k);
        press_key(k);
        check_all();
    endtask

    task automatic test_cursor();
        repeat (14) step_and_check(k_right);  // last one wraps to year thousands
        step_and_check(k_left);
        step_and_check(k_left);
        hold_key(k_right, 3 * hold_cycles);  // moves once despite the long hold
        check_all();
        @(posedge clk);
        mode <= 4'd1;
        press_key(k_right);
        press_key(k_up);
        check_all();
        @(posedge clk);
        mode <= clock_set_pkg::mode_set;
    endtask

    task automatic test_time_wraps();
        move_to(clock_set_pkg::cur_hour_t);
        step_and_check(k_down);
        step_and_check(k_up);
        set_digit(clock_set_pkg::cur_min_t, 5);
        step_and_check(k_up);
        step_and_check(k_down);
        set_digit(clock_set_pkg::cur_sec_t, 5);
        step_and_check(k_up);
        set_digit(clock_set_pkg::cur_sec_u, 9);
        step_and_check(k_up);
        set_digit(clock_set_pkg::cur_year_th, 0);
        set_digit(clock_set_pkg::cur_year_t, 0);
        set_digit(clock_set_pkg::cur_year_u, 1);
        step_and_check(k_down);  // 0001 down skips 0000
        step_and_check(k_up);
    endtask

    task automatic test_calendar();
        set_digit(clock_set_pkg::cur_year_th, 2);
        set_digit(clock_set_pkg::cur_year_t, 2);
        set_digit(clock_set_pkg::cur_year_u, 4);
        set_digit(clock_set_pkg::cur_month_u, 2);
        set_digit(clock_set_pkg::cur_day_t, 2);
        step_and_check(k_up);
        set_digit(clock_set_pkg::cur_day_t, 2);
        set_digit(clock_set_pkg::cur_day_u, 9);
        step_and_check(k_up);  // feb 29 in 2024
        set_digit(clock_set_pkg::cur_year_u, 3);
        set_digit(clock_set_pkg::cur_day_u, 8);
        step_and_check(k_up);
        set_digit(clock_set_pkg::cur_month_u, 4);
        set_digit(clock_set_pkg::cur_day_t, 3);
        step_and_check(k_up);  // units pinned at 0 in april
        set_digit(clock_set_pkg::cur_month_t, 1);
        set_digit(clock_set_pkg::cur_month_u, 2);
        move_to(clock_set_pkg::cur_day_u);
        step_and_check(k_up);
        step_and_check(k_up);
        move_to(clock_set_pkg::cur_month_u);
        step_and_check(k_up);
        step_and_check(k_down);
        set_digit(clock_set_pkg::cur_month_t, 0);
        set_digit(clock_set_pkg::cur_month_u, 9);
        step_and_check(k_up);
        step_and_check(k_down);
    endtask

    task automatic test_random_dates();
        clock_set_pkg::date_time_t target;
        int y;
        int m;
        int d;
        int h;
        int mi;
        int s;
        repeat (6) begin
            y = 1583 + rand_below(8417);
            m = 1 + rand_below(12);
            d = 1 + rand_below(days_in_month(y, m));
            h = rand_below(24);
            mi = rand_below(60);
            s = rand_below(60);
            target = make_date(y, m, d, h, mi, s);
            for (int c = 0; c < 14; c++) begin
                set_digit(clock_set_pkg::cursor_t'(c),
                          int'(digit_of(target, clock_set_pkg::cursor_t'(c))));
            end
            check_date(now, target);
            check_week(week, weekday_of(target));
            check_string(set_string, pack_string(target));
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: tests did not finish within %0d ns", timeout_ns);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mode = clock_set_pkg::mode_set;
        key_left = 1'b0;
        key_right = 1'b0;
        key_up = 1'b0;
        key_down = 1'b0;
        model_date = make_date(2023, 1, 1, 0, 0, 0);
        model_cur = clock_set_pkg::cur_year_th;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_all();
        check_week(week, 4'd7);  // 2023-01-01 was a sunday
        test_cursor();
        test_time_wraps();
        test_calendar();
        test_random_dates();
        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- clock_set_top.sv
module clock_set_top #(
    parameter int hold_cycles = 8
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [3:0]                                mode,
    input  logic                                      key_left,
    input  logic                                      key_right,
    input  logic                                      key_up,
    input  logic                                      key_down,
    output clock_set_pkg::date_time_t                 now,
    output clock_set_pkg::weekday_t                   week,
    output logic [clock_set_pkg::display_width - 1:0] set_string,
    output clock_set_pkg::cursor_t                    cursor
);

    clock_set_pkg::edit_cmd_t cmd;

    cursor_ctrl #(
        .hold_cycles(hold_cycles)
    ) i_cursor_ctrl (
        .clk      (clk),
        .reset    (reset),
        .mode     (mode),
        .key_left (key_left),
        .key_right(key_right),
        .key_up   (key_up),
        .key_down (key_down),
        .cmd      (cmd),
        .cursor   (cursor)
    );

    date_regs i_date_regs (
        .clk  (clk),
        .reset(reset),
        .cmd  (cmd),
        .now  (now)
    );

    date_display i_date_display (
        .now       (now),
        .week      (week),
        .set_string(set_string)
    );

endmodule

//--- date_display.sv
module date_display (
    input  clock_set_pkg::date_time_t                 now,
    output clock_set_pkg::weekday_t                   week,
    output logic [clock_set_pkg::display_width - 1:0] set_string
);

    logic [13:0] year_bin;
    logic [13:0] year_adj;
    logic [4:0]  month_bin;
    logic [4:0]  month_adj;
    logic [5:0]  day_bin;
    logic [15:0] day_sum;
    logic [15:0] day_mod;

    always_comb begin
        year_bin = 14'(now.year[3]) * 14'd1000 + 14'(now.year[2]) * 14'd100 +
                   14'(now.year[1]) * 14'd10 + 14'(now.year[0]);
        month_bin = 5'(now.month[1]) * 5'd10 + 5'(now.month[0]);
        day_bin   = 6'(now.day[1]) * 6'd10 + 6'(now.day[0]);

        // jan and feb count as months 13 and 14 of the year before
        if (month_bin == 5'd1 || month_bin == clock_set_pkg::month_feb) begin
            month_adj = month_bin + 5'd12;
            year_adj  = year_bin - 14'd1;
        end else begin
            month_adj = month_bin;
            year_adj  = year_bin;
        end
    end

    always_comb begin
        day_sum = 16'(day_bin)
                + 16'(month_adj) * 16'd2
                + (16'(month_adj) + 16'd1) * 16'd3 / 16'd5
                + 16'(year_adj)
                + 16'(year_adj) / 16'd4
                - 16'(year_adj) / 16'd100
                + 16'(year_adj) / 16'd400
                + 16'd1;
        day_mod = day_sum % 16'd7;
    end

    assign week = (day_mod == 16'd0) ? 4'd7 : day_mod[3:0];  // 0 is sunday

    assign set_string = {
        now.year,
        clock_set_pkg::field_sep,
        now.month,
        clock_set_pkg::field_sep,
        now.day,
        clock_set_pkg::field_sep,
        week,
        clock_set_pkg::field_sep,
        now.hour,
        clock_set_pkg::field_sep,
        now.minute,
        clock_set_pkg::field_sep,
        now.second
    };

endmodule

//--- date_regs.sv
module date_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  clock_set_pkg::edit_cmd_t  cmd,
    output clock_set_pkg::date_time_t now
);

    clock_set_pkg::bcd_digit_t [clock_set_pkg::num_digits - 1:0] digits;
    clock_set_pkg::bcd_digit_t [clock_set_pkg::num_digits - 1:0] next_digits;
    clock_set_pkg::bcd_digit_t lo;
    clock_set_pkg::bcd_digit_t hi;
    logic [4:0] month_bin;
    logic [6:0] year_lo2;
    logic [6:0] year_hi2;
    logic       leap;
    logic       feb;
    logic       long_month;
    logic       strobe;
    logic       valid;
    int         sel;

    function automatic clock_set_pkg::bcd_digit_t wrap_step(
        input clock_set_pkg::bcd_digit_t d,
        input clock_set_pkg::bcd_digit_t lo_lim,
        input clock_set_pkg::bcd_digit_t hi_lim,
        input logic up
    );
        clock_set_pkg::bcd_digit_t r;
        if (up) begin
            r = (d >= hi_lim) ? lo_lim : d + 4'd1;
        end else begin
            r = (d <= lo_lim) ? hi_lim : d - 4'd1;
        end
        return r;
    endfunction

    assign digits = now;  // cursor k sits at digits[13-k]

    assign month_bin = 5'(now.month[1]) * 5'd10 + 5'(now.month[0]);
    assign year_lo2  = 7'(now.year[1]) * 7'd10 + 7'(now.year[0]);
    assign year_hi2  = 7'(now.year[3]) * 7'd10 + 7'(now.year[2]);

    // div by 400 when the low two digits are 00, else div by 4
    assign leap = (year_lo2 == 7'd0) ? (year_hi2[1:0] == 2'd0) : (year_lo2[1:0] == 2'd0);

    assign feb = (month_bin == clock_set_pkg::month_feb);
    assign long_month = (month_bin <= 5'd12) &&
                        clock_set_pkg::long_month_mask[month_bin[3:0]];

    assign strobe = cmd.step_up || cmd.step_down;

    always_comb begin
        lo    = 4'd0;
        hi    = clock_set_pkg::digit_max;
        valid = 1'b1;
        case (cmd.target)
            clock_set_pkg::cur_year_th,
            clock_set_pkg::cur_year_h,
            clock_set_pkg::cur_year_t: ;
            clock_set_pkg::cur_year_u: begin
                if (now.year[3:1] == '0) begin
                    lo = 4'd1;  // year never 0000
                end
            end
            clock_set_pkg::cur_month_t: hi = clock_set_pkg::month_tens_max;
            clock_set_pkg::cur_month_u: begin
                if (now.month[1] == 4'd1) begin
                    hi = clock_set_pkg::dec_units_max;
                end else begin
                    lo = 4'd1;
                end
            end
            clock_set_pkg::cur_day_t: begin
                hi = feb ? clock_set_pkg::feb_day_tens_max : clock_set_pkg::day_tens_max;
            end
            clock_set_pkg::cur_day_u: begin
                if (feb && now.day[1] == 4'd2) begin
                    hi = leap ? clock_set_pkg::digit_max : clock_set_pkg::feb_units_max;
                end else if (!feb && now.day[1] == 4'd3) begin
                    // 30-day months pin the units at 0
                    hi = long_month ? clock_set_pkg::long_month_units_max : 4'd0;
                end else if (now.day[1] == 4'd0) begin
                    lo = 4'd1;
                end
            end
            clock_set_pkg::cur_hour_t: hi = clock_set_pkg::hour_tens_max;
            clock_set_pkg::cur_min_t,
            clock_set_pkg::cur_sec_t: hi = clock_set_pkg::sexa_tens_max;
            clock_set_pkg::cur_hour_u,
            clock_set_pkg::cur_min_u,
            clock_set_pkg::cur_sec_u: ;
            default: valid = 1'b0;
        endcase
    end

    always_comb begin
        next_digits = digits;
        sel = clock_set_pkg::num_digits - 1 - int'(cmd.target);
        if (strobe && valid) begin
            next_digits[sel] = wrap_step(digits[sel], lo, hi, cmd.step_up);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            now <= clock_set_pkg::reset_date;
        end else begin
            now <= clock_set_pkg::date_time_t'(next_digits);
        end
    end

endmodule

//--- cursor_ctrl.sv
module cursor_ctrl #(
    parameter int hold_cycles = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [3:0]              mode,
    input  logic                    key_left,
    input  logic                    key_right,
    input  logic                    key_up,
    input  logic                    key_down,
    output clock_set_pkg::edit_cmd_t cmd,
    output clock_set_pkg::cursor_t   cursor
);

    logic set_mode;
    logic left_pulse;
    logic right_pulse;
    logic up_pulse;
    logic down_pulse;

    assign set_mode = (mode == clock_set_pkg::mode_set);

    key_hold #(
        .hold_cycles(hold_cycles)
    ) i_move_keys (
        .clk    (clk),
        .reset  (reset),
        .enable (set_mode),
        .key_a  (key_left),
        .key_b  (key_right),
        .pulse_a(left_pulse),
        .pulse_b(right_pulse)
    );

    key_hold #(
        .hold_cycles(hold_cycles)
    ) i_step_keys (
        .clk    (clk),
        .reset  (reset),
        .enable (set_mode),
        .key_a  (key_up),
        .key_b  (key_down),
        .pulse_a(up_pulse),
        .pulse_b(down_pulse)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            cursor <= clock_set_pkg::reset_cursor;
        end else if (left_pulse) begin
            if (cursor == clock_set_pkg::cur_year_th) begin
                cursor <= clock_set_pkg::cur_sec_u;  // wrap to last digit
            end else begin
                cursor <= clock_set_pkg::cursor_t'(cursor - 4'd1);
            end
        end else if (right_pulse) begin
            if (cursor == clock_set_pkg::cur_sec_u) begin
                cursor <= clock_set_pkg::cur_year_th;
            end else begin
                cursor <= clock_set_pkg::cursor_t'(cursor + 4'd1);
            end
        end
    end

    always_comb begin
        cmd.target    = cursor;
        cmd.step_up   = up_pulse;  // one cycle each
        cmd.step_down = down_pulse;
    end

endmodule

//--- key_hold.sv
module key_hold #(
    parameter int hold_cycles = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic key_a,
    input  logic key_b,
    output logic pulse_a,
    output logic pulse_b
);

    logic [$clog2(hold_cycles + 1) - 1:0] hold_cnt;
    logic held;
    logic at_hold;

    assign held = enable && (key_a || key_b);
    // last cycle before the count reaches hold_cycles
    assign at_hold = held && (int'(hold_cnt) == hold_cycles - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt <= '0;
            pulse_a  <= 1'b0;
            pulse_b  <= 1'b0;
        end else begin
            pulse_a <= at_hold && key_a;  // a wins over b
            pulse_b <= at_hold && !key_a && key_b;
            if (!held) begin
                hold_cnt <= '0;
            end else if (int'(hold_cnt) != hold_cycles) begin
                hold_cnt <= hold_cnt + 1'b1;  // saturates, no repeat
            end
        end
    end

endmodule

//--- clock_set_pkg.sv
package clock_set_pkg;

    typedef logic [3:0] bcd_digit_t;
    typedef logic [3:0] weekday_t;  // 1 = monday .. 7 = sunday

    typedef struct packed {
        bcd_digit_t [3:0] year;  // [3] is thousands
        bcd_digit_t [1:0] month;  // [1] is tens
        bcd_digit_t [1:0] day;
        bcd_digit_t [1:0] hour;
        bcd_digit_t [1:0] minute;
        bcd_digit_t [1:0] second;
    } date_time_t;

    // digit order matches the packed date_time_t, msb first
    typedef enum logic [3:0] {
        cur_year_th,
        cur_year_h,
        cur_year_t,
        cur_year_u,
        cur_month_t,
        cur_month_u,
        cur_day_t,
        cur_day_u,
        cur_hour_t,
        cur_hour_u,
        cur_min_t,
        cur_min_u,
        cur_sec_t,
        cur_sec_u
    } cursor_t;

    typedef struct packed {
        cursor_t target;
        logic    step_up;
        logic    step_down;
    } edit_cmd_t;

    localparam logic [3:0] mode_set = 4'd0;
    localparam bcd_digit_t field_sep = 4'hb;
    localparam int display_width = 84;
    localparam int num_digits = 14;

    localparam bcd_digit_t digit_max = 4'd9;
    localparam bcd_digit_t month_tens_max = 4'd1;
    localparam bcd_digit_t dec_units_max = 4'd2;  // months 10..12
    localparam bcd_digit_t day_tens_max = 4'd3;
    localparam bcd_digit_t feb_day_tens_max = 4'd2;
    localparam bcd_digit_t feb_units_max = 4'd8;  // common year, day 28
    localparam bcd_digit_t long_month_units_max = 4'd1;
    localparam bcd_digit_t hour_tens_max = 4'd2;
    localparam bcd_digit_t sexa_tens_max = 4'd5;  // minutes and seconds

    localparam logic [4:0] month_feb = 5'd2;
    // bit n set when month n has 31 days
    localparam logic [12:0] long_month_mask = 13'b1_0101_1010_1010;

    localparam date_time_t reset_date = '{
        year:   16'h2023,
        month:  8'h01,
        day:    8'h01,
        hour:   8'h00,
        minute: 8'h00,
        second: 8'h00
    };

    localparam cursor_t reset_cursor = cur_year_th;

endpackage
